/* qs.f */
+incdir+design
design/qs_pkg.sv
design/qs_enq.sv
design/qs_bank.sv
design/qs_sort.sv
design/qs_deq.sv
design/qs_top.sv
tests/qs_checker.sv
tests/tb_qs.sv

/* Bender.yml */
package:
  name: qs

sources:
  - include_dirs:
      - design
    files:
      - design/qs_pkg.sv
      - design/qs_enq.sv
      - design/qs_bank.sv
      - design/qs_sort.sv
      - design/qs_deq.sv
      - design/qs_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - tests/qs_checker.sv
      - tests/tb_qs.sv

/* tests/tb_qs.sv */
// Testbench top for the sort accelerator, drives planned packets and prints the checker verdict
module tb_qs
  import qs_pkg::*;
();

  logic clk = 1'b0;
  logic arst_n;
  logic in_vld;
  logic in_sop;
  logic in_eop;
  w_t   in_dat;
  logic in_rdy;
  logic out_vld;
  logic out_sop;
  logic out_eop;
  logic out_err;
  w_t   out_dat;

  int pkts_in;
  int pkts_out;
  int err_cnt;

  // Packet plan, built before reset
  int plan_test [32];
  int plan_len  [32];
  int plan_kind [32];
  int n_plan;
  w_t pkt [32];

  logic [31:0] rng_q;
  int          cycle_cnt = 0;
  int          cycle_limit;

  always #5 clk = ~clk;

  qs_top qs_top_inst (
    .clk     (clk),
    .arst_n  (arst_n),
    .in_vld  (in_vld),
    .in_sop  (in_sop),
    .in_eop  (in_eop),
    .in_dat  (in_dat),
    .in_rdy  (in_rdy),
    .out_vld (out_vld),
    .out_sop (out_sop),
    .out_eop (out_eop),
    .out_err (out_err),
    .out_dat (out_dat)
  );

  qs_checker qs_checker_inst (
    .clk      (clk),
    .arst_n   (arst_n),
    .in_vld   (in_vld),
    .in_eop   (in_eop),
    .in_dat   (in_dat),
    .in_rdy   (in_rdy),
    .out_vld  (out_vld),
    .out_sop  (out_sop),
    .out_eop  (out_eop),
    .out_err  (out_err),
    .out_dat  (out_dat),
    .pkts_in  (pkts_in),
    .pkts_out (pkts_out),
    .err_cnt  (err_cnt)
  );

  // LCG step
  function automatic logic [31:0] lcg_next();
    rng_q = rng_q * 32'd1664525 + 32'd1013904223;
    return rng_q;
  endfunction

  function automatic string test_name(input int t);
    case (t)
      1: return "single packet";
      2: return "edge lengths";
      3: return "overflow";
      4: return "back to back";
      5: return "gaps and idle offers";
      default: return "ordered patterns";
    endcase
  endfunction

  task automatic add_packet(input int t, input int len, input int kind);
    plan_test[n_plan] = t;
    plan_len[n_plan]  = len;
    plan_kind[n_plan] = kind;
    n_plan++;
  endtask

  // Kind 0 random, 1 ascending, 2 descending, 3 all equal
  task automatic plan_tests();
    n_plan = 0;
    add_packet(1, 8, 0);
    add_packet(2, 1, 0);
    add_packet(2, 16, 0);
    add_packet(3, 20, 0);
    add_packet(3, 5, 0);
    for (int k = 0; k < 12; k++) begin
      add_packet(4, 1 + (lcg_next() >> 16) % 20, 0);
    end
    for (int k = 0; k < 4; k++) begin
      add_packet(5, 2 + (lcg_next() >> 16) % 11, 0);
    end
    add_packet(6, 10, 1);
    add_packet(6, 16, 2);
    add_packet(6, 7, 3);
  endtask

  task automatic fill_packet(input int len, input int kind);
    w_t base;
    // Headroom so the ramps never wrap
    base = lcg_next() >> 4;
    for (int i = 0; i < len; i++) begin
      case (kind)
        1: pkt[i] = base + w_t'(i * 3);
        2: pkt[i] = base + w_t'((len - i) * 3);
        3: pkt[i] = base;
        default: pkt[i] = lcg_next();
      endcase
    end
  endtask

  // Offers each word until taken, optional idle cycles and junk after eop
  task automatic send_packet(input int len, input bit gaps);
    int i;
    i = 0;
    while (i < len) begin
      if (gaps && ((lcg_next() >> 24) % 3) == 0) begin
        in_vld <= 1'b0;
        in_sop <= 1'b1;
        in_eop <= 1'b1;
        in_dat <= w_t'(32'hdead_0000 + i);
      end else begin
        in_vld <= 1'b1;
        in_sop <= (i == 0);
        in_eop <= (i == len - 1);
        in_dat <= pkt[i];
      end
      @(posedge clk);
      if (in_vld && in_rdy) begin
        i++;
      end
    end
    if (gaps) begin
      // in_rdy stays low for at least three cycles after eop
      in_vld <= 1'b1;
      in_sop <= 1'b1;
      in_eop <= 1'b0;
      in_dat <= w_t'(32'hbad0_0001);
      @(posedge clk);
      in_dat <= w_t'(32'hbad0_0002);
      @(posedge clk);
    end
    in_vld <= 1'b0;
    in_sop <= 1'b0;
    in_eop <= 1'b0;
  endtask

  // Run limit from the planned lengths
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("timeout after %0d cycles, not all packets came out", cycle_cnt);
      $display("Result: FAILED");
      $finish;
    end
  end

  initial begin
    int t;
    int p;
    int sent;
    int err_before;
    bit ok;
    rng_q  = 32'hef80_7970;
    arst_n = 1'b0;
    in_vld = 1'b0;
    in_sop = 1'b0;
    in_eop = 1'b0;
    in_dat = '0;
    plan_tests();
    cycle_limit = 20;
    for (int k = 0; k < n_plan; k++) begin
      cycle_limit += plan_len[k] * plan_len[k] * 8;
    end
    repeat (10) @(posedge clk);
    arst_n <= 1'b1;
    p    = 0;
    sent = 0;
    for (t = 1; t <= 6; t++) begin
      err_before = err_cnt;
      while (p < n_plan && plan_test[p] == t) begin
        fill_packet(plan_len[p], plan_kind[p]);
        send_packet(plan_len[p], t == 5);
        p++;
        sent++;
      end
      // Drain before the next test
      while (pkts_out < sent) @(posedge clk);
      $display("test %0d %s: %0d packets out, %0d errors, %s", t, test_name(t), pkts_out,
               err_cnt - err_before, (err_cnt == err_before) ? "ok" : "bad");
    end
    ok = (err_cnt == 0);
    if (pkts_in != sent) begin
      $display("input side took %0d packets but %0d were sent", pkts_in, sent);
      ok = 1'b0;
    end
    $display("summary: 6 tests, %0d packets in, %0d packets out, %0d errors",
             pkts_in, pkts_out, err_cnt);
    if (ok) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* tests/qs_checker.sv */
// Scoreboard for the sort accelerator, rebuilds each accepted packet and checks the output stream
`include "qs_macros.svh"

module qs_checker
  import qs_pkg::*;
(
  input  logic clk,
  input  logic arst_n,
  input  logic in_vld,
  input  logic in_eop,
  input  w_t   in_dat,
  input  logic in_rdy,
  input  logic out_vld,
  input  logic out_sop,
  input  logic out_eop,
  input  logic out_err,
  input  w_t   out_dat,
  output int   pkts_in,
  output int   pkts_out,
  output int   err_cnt
);

  // Words of the packet being accepted
  w_t cur [64];
  int cur_len;
  int m;

  // Cycles after an accepted eop in which in_rdy must stay low
  int rdy_low;

  // Expected output, one entry per word
  w_t   exp_dat [$];
  logic exp_sop [$];
  logic exp_eop [$];
  logic exp_err [$];

  w_t   e_dat;
  logic e_sop;
  logic e_eop;
  logic e_err;

  // Word k of the packet after truncation to one bank and ascending order
  function automatic w_t ref_word(input int k);
    int n;
    int lt;
    int le;
    n = (cur_len > `QS_DEPTH) ? `QS_DEPTH : cur_len;
    // Rank of each candidate, duplicates span a range of ranks
    for (int i = 0; i < n; i++) begin
      lt = 0;
      le = 0;
      for (int j = 0; j < n; j++) begin
        if (cur[j] < cur[i]) begin
          lt++;
        end
        if (cur[j] <= cur[i]) begin
          le++;
        end
      end
      if (k >= lt && k < le) begin
        return cur[i];
      end
    end
    return '0;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
    $display("ERR %s exp %h act %h", name, exp_v, act_v);
    err_cnt++;
  endtask

  // Sampled mid cycle, inputs and outputs both settled
  always @(negedge clk) begin
    if (!arst_n) begin
      cur_len = 0;
      rdy_low = 0;
    end else begin
      // Next bank is not claimed yet, so nothing may be taken
      if (rdy_low > 0) begin
        if (in_rdy) begin
          $display("in_rdy high %0d cycles after eop, before the next bank was claimed",
                   3 - rdy_low);
          err_cnt++;
        end
        rdy_low--;
      end
      // Input side, only words the DUT actually took
      if (in_vld && in_rdy) begin
        if (cur_len < 64) begin
          cur[cur_len] = in_dat;
        end
        cur_len++;
        if (in_eop) begin
          m = (cur_len > `QS_DEPTH) ? `QS_DEPTH : cur_len;
          for (int k = 0; k < m; k++) begin
            exp_dat.push_back(ref_word(k));
            exp_sop.push_back(k == 0);
            exp_eop.push_back(k == m - 1);
            exp_err.push_back(k == m - 1 && cur_len > `QS_DEPTH);
          end
          pkts_in++;
          cur_len = 0;
          rdy_low = 2;
        end
      end
      // Output side, in arrival order
      if (out_vld) begin
        if (exp_dat.size() == 0) begin
          $display("extra word %h on the output with no packet pending", out_dat);
          err_cnt++;
        end else begin
          e_dat = exp_dat.pop_front();
          e_sop = exp_sop.pop_front();
          e_eop = exp_eop.pop_front();
          e_err = exp_err.pop_front();
          if (out_dat !== e_dat) begin
            report_mismatch("out_dat", e_dat, out_dat);
          end
          if (e_sop && out_sop !== 1'b1) begin
            $display("missing sop on the first word of output packet %0d", pkts_out);
            err_cnt++;
          end else if (!e_sop && out_sop !== 1'b0) begin
            report_mismatch("out_sop", e_sop, out_sop);
          end
          if (e_eop && out_eop !== 1'b1) begin
            $display("missing eop on the last word of output packet %0d", pkts_out);
            err_cnt++;
          end else if (!e_eop && out_eop !== 1'b0) begin
            report_mismatch("out_eop", e_eop, out_eop);
          end
          if (out_err !== e_err) begin
            report_mismatch("out_err", e_err, out_err);
          end
          if (e_eop) begin
            pkts_out++;
          end
        end
      end
    end
  end

endmodule

/* design/qs_top.sv */
// Top of the sort accelerator, joins enqueue, bank storage, sort engine and dequeue
module qs_top
  import qs_pkg::*;
(
  input  logic clk,
  input  logic arst_n,
  input  logic in_vld,
  input  logic in_sop,
  input  logic in_eop,
  input  w_t   in_dat,
  output logic in_rdy,
  output logic out_vld,
  output logic out_sop,
  output logic out_eop,
  output logic out_err,
  output w_t   out_dat
);

  // Enqueue to banks
  bank_id_t     enq_bank_idx;
  bank_status_t enq_status;
  logic         enq_upd_vld;
  bank_status_t enq_upd_status;
  addr_t        enq_upd_n;
  logic         enq_upd_err;
  logic         enq_wr_en;
  addr_t        enq_wr_addr;
  w_t           enq_wr_data;

  // Sort to banks
  bank_id_t     sort_bank_idx;
  bank_status_t sort_status;
  addr_t        sort_n;
  logic         sort_upd_vld;
  bank_status_t sort_upd_status;
  logic         sort_rd_en;
  addr_t        sort_rd_addr;
  w_t           sort_rd_data;
  logic         sort_wr_en;
  addr_t        sort_wr_addr;
  w_t           sort_wr_data;

  // Dequeue to banks
  bank_id_t     deq_bank_idx;
  bank_status_t deq_status;
  addr_t        deq_n;
  logic         deq_err;
  logic         deq_upd_vld;
  bank_status_t deq_upd_status;
  logic         deq_rd_en;
  addr_t        deq_rd_addr;
  w_t           deq_rd_data;

  qs_enq qs_enq_inst (
    .clk         (clk),
    .arst_n      (arst_n),
    .in_vld      (in_vld),
    .in_sop      (in_sop),
    .in_eop      (in_eop),
    .in_dat      (in_dat),
    .in_rdy      (in_rdy),
    .bank_status (enq_status),
    .bank_idx    (enq_bank_idx),
    .upd_vld     (enq_upd_vld),
    .upd_status  (enq_upd_status),
    .upd_n       (enq_upd_n),
    .upd_err     (enq_upd_err),
    .wr_en       (enq_wr_en),
    .wr_addr     (enq_wr_addr),
    .wr_data     (enq_wr_data)
  );

  qs_bank qs_bank_inst (
    .clk             (clk),
    .arst_n          (arst_n),
    .enq_bank_idx    (enq_bank_idx),
    .enq_status      (enq_status),
    .enq_upd_vld     (enq_upd_vld),
    .enq_upd_status  (enq_upd_status),
    .enq_upd_n       (enq_upd_n),
    .enq_upd_err     (enq_upd_err),
    .enq_wr_en       (enq_wr_en),
    .enq_wr_addr     (enq_wr_addr),
    .enq_wr_data     (enq_wr_data),
    .sort_bank_idx   (sort_bank_idx),
    .sort_status     (sort_status),
    .sort_n          (sort_n),
    .sort_upd_vld    (sort_upd_vld),
    .sort_upd_status (sort_upd_status),
    .sort_rd_en      (sort_rd_en),
    .sort_rd_addr    (sort_rd_addr),
    .sort_rd_data    (sort_rd_data),
    .sort_wr_en      (sort_wr_en),
    .sort_wr_addr    (sort_wr_addr),
    .sort_wr_data    (sort_wr_data),
    .deq_bank_idx    (deq_bank_idx),
    .deq_status      (deq_status),
    .deq_n           (deq_n),
    .deq_err         (deq_err),
    .deq_upd_vld     (deq_upd_vld),
    .deq_upd_status  (deq_upd_status),
    .deq_rd_en       (deq_rd_en),
    .deq_rd_addr     (deq_rd_addr),
    .deq_rd_data     (deq_rd_data)
  );

  qs_sort qs_sort_inst (
    .clk         (clk),
    .arst_n      (arst_n),
    .bank_status (sort_status),
    .bank_n      (sort_n),
    .rd_data     (sort_rd_data),
    .bank_idx    (sort_bank_idx),
    .upd_vld     (sort_upd_vld),
    .upd_status  (sort_upd_status),
    .rd_en       (sort_rd_en),
    .rd_addr     (sort_rd_addr),
    .wr_en       (sort_wr_en),
    .wr_addr     (sort_wr_addr),
    .wr_data     (sort_wr_data)
  );

  qs_deq qs_deq_inst (
    .clk         (clk),
    .arst_n      (arst_n),
    .bank_status (deq_status),
    .bank_n      (deq_n),
    .bank_err    (deq_err),
    .rd_data     (deq_rd_data),
    .bank_idx    (deq_bank_idx),
    .upd_vld     (deq_upd_vld),
    .upd_status  (deq_upd_status),
    .rd_en       (deq_rd_en),
    .rd_addr     (deq_rd_addr),
    .out_vld     (out_vld),
    .out_sop     (out_sop),
    .out_eop     (out_eop),
    .out_err     (out_err),
    .out_dat     (out_dat)
  );

endmodule

/* design/qs_deq.sv */
// Dequeue FSM, streams a sorted bank out as one packet and hands the bank back to enqueue
module qs_deq
  import qs_pkg::*;
(
  input  logic         clk,
  input  logic         arst_n,
  input  bank_status_t bank_status,
  input  addr_t        bank_n,
  input  logic         bank_err,
  input  w_t           rd_data,
  output bank_id_t     bank_idx,
  output logic         upd_vld,
  output bank_status_t upd_status,
  output logic         rd_en,
  output addr_t        rd_addr,
  output logic         out_vld,
  output logic         out_sop,
  output logic         out_eop,
  output logic         out_err,
  output w_t           out_dat
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT,
    ST_READ
  } state_t;

  state_t state_q;
  addr_t  addr_q;
  logic   last;

  // One read per cycle while streaming
  assign rd_en   = (state_q == ST_READ);
  assign rd_addr = addr_q;
  assign last    = (addr_q == bank_n);

  // Read register of the bank feeds the output
  assign out_dat = rd_data;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q    <= ST_IDLE;
      addr_q     <= '0;
      bank_idx   <= '0;
      upd_vld    <= 1'b0;
      upd_status <= BANK_IDLE;
      out_vld    <= 1'b0;
      out_sop    <= 1'b0;
      out_eop    <= 1'b0;
      out_err    <= 1'b0;
    end else begin
      upd_vld <= 1'b0;
      // Flags line up with the read data
      out_vld <= rd_en;
      out_sop <= rd_en && addr_q == '0;
      out_eop <= rd_en && last;
      out_err <= rd_en && last && bank_err;
      // Step after the free has gone out for the old bank
      if (upd_vld && upd_status == BANK_IDLE) begin
        bank_idx <= bank_id_inc(bank_idx);
      end
      case (state_q)
        ST_IDLE: begin
          if (bank_status == BANK_SORTED) begin
            upd_vld    <= 1'b1;
            upd_status <= BANK_UNLOADING;
            addr_q     <= '0;
            state_q    <= ST_WAIT;
          end
        end
        // Claim lands in the record, memory is ours next cycle
        ST_WAIT: state_q <= ST_READ;
        ST_READ: begin
          addr_q <= addr_q + 1'b1;
          if (last) begin
            // Last read issued, data still in flight
            upd_vld    <= 1'b1;
            upd_status <= BANK_IDLE;
            state_q    <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

endmodule

/* design/qs_sort.sv */
// Sort engine, runs in-place exchange passes over a ready bank until a pass makes no swap
module qs_sort
  import qs_pkg::*;
(
  input  logic         clk,
  input  logic         arst_n,
  input  bank_status_t bank_status,
  input  addr_t        bank_n,
  input  w_t           rd_data,
  output bank_id_t     bank_idx,
  output logic         upd_vld,
  output bank_status_t upd_status,
  output logic         rd_en,
  output addr_t        rd_addr,
  output logic         wr_en,
  output addr_t        wr_addr,
  output w_t           wr_data
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_READ_A,
    ST_READ_B,
    ST_COMPARE,
    ST_WRITE_A,
    ST_WRITE_B,
    ST_PASS_END
  } state_t;

  state_t state_q;
  addr_t  i_q;
  addr_t  i_nxt;
  logic   last;
  logic   swapped_q;
  w_t     a_q;
  w_t     b_q;

  // Current pair is (i, i+1)
  assign i_nxt = i_q + 1'b1;
  assign last  = (i_nxt == bank_n);

  // Memory port from state
  assign rd_en   = (state_q == ST_READ_A) || (state_q == ST_READ_B);
  assign rd_addr = (state_q == ST_READ_B) ? i_nxt : i_q;
  assign wr_en   = (state_q == ST_WRITE_A) || (state_q == ST_WRITE_B);
  assign wr_addr = (state_q == ST_WRITE_B) ? i_nxt : i_q;
  // Swap puts the smaller word first
  assign wr_data = (state_q == ST_WRITE_B) ? a_q : b_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q    <= ST_IDLE;
      i_q        <= '0;
      swapped_q  <= 1'b0;
      bank_idx   <= '0;
      upd_vld    <= 1'b0;
      upd_status <= BANK_IDLE;
    end else begin
      upd_vld <= 1'b0;
      // Step once SORTED has gone out for the old bank
      if (upd_vld && upd_status == BANK_SORTED) begin
        bank_idx <= bank_id_inc(bank_idx);
      end
      case (state_q)
        ST_IDLE: begin
          if (bank_status == BANK_READY) begin
            upd_vld    <= 1'b1;
            upd_status <= BANK_SORTING;
            // Forces the first pass, PASS_END also covers the claim delay
            swapped_q  <= 1'b1;
            state_q    <= ST_PASS_END;
          end
        end
        ST_READ_A: state_q <= ST_READ_B;
        ST_READ_B: state_q <= ST_COMPARE;
        ST_COMPARE: begin
          // rd_data holds word i+1 here
          if (a_q > rd_data) begin
            swapped_q <= 1'b1;
            state_q   <= ST_WRITE_A;
          end else begin
            i_q     <= i_nxt;
            state_q <= last ? ST_PASS_END : ST_READ_A;
          end
        end
        ST_WRITE_A: state_q <= ST_WRITE_B;
        ST_WRITE_B: begin
          i_q     <= i_nxt;
          state_q <= last ? ST_PASS_END : ST_READ_A;
        end
        ST_PASS_END: begin
          if (swapped_q) begin
            // New pass from the start, single word bank has no pairs
            swapped_q <= 1'b0;
            i_q       <= '0;
            state_q   <= (bank_n == '0) ? ST_PASS_END : ST_READ_A;
          end else begin
            upd_vld    <= 1'b1;
            upd_status <= BANK_SORTED;
            state_q    <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Pair capture
  always_ff @(posedge clk) begin
    if (state_q == ST_READ_B) begin
      a_q <= rd_data;
    end
    if (state_q == ST_COMPARE) begin
      b_q <= rd_data;
    end
  end

endmodule

/* design/qs_bank.sv */
// Bank storage, holds each bank's memory and status record and steers each memory to its owner
`include "qs_macros.svh"

module qs_bank
  import qs_pkg::*;
(
  input  logic         clk,
  input  logic         arst_n,
  // Enqueue client
  input  bank_id_t     enq_bank_idx,
  output bank_status_t enq_status,
  input  logic         enq_upd_vld,
  input  bank_status_t enq_upd_status,
  input  addr_t        enq_upd_n,
  input  logic         enq_upd_err,
  input  logic         enq_wr_en,
  input  addr_t        enq_wr_addr,
  input  w_t           enq_wr_data,
  // Sort client
  input  bank_id_t     sort_bank_idx,
  output bank_status_t sort_status,
  output addr_t        sort_n,
  input  logic         sort_upd_vld,
  input  bank_status_t sort_upd_status,
  input  logic         sort_rd_en,
  input  addr_t        sort_rd_addr,
  output w_t           sort_rd_data,
  input  logic         sort_wr_en,
  input  addr_t        sort_wr_addr,
  input  w_t           sort_wr_data,
  // Dequeue client
  input  bank_id_t     deq_bank_idx,
  output bank_status_t deq_status,
  output addr_t        deq_n,
  output logic         deq_err,
  input  logic         deq_upd_vld,
  input  bank_status_t deq_upd_status,
  input  logic         deq_rd_en,
  input  addr_t        deq_rd_addr,
  output w_t           deq_rd_data
);

  // Status records
  bank_status_t status_q [`QS_BANKS];
  addr_t        n_q      [`QS_BANKS];
  logic         err_q    [`QS_BANKS];

  // Word storage and per bank read register
  w_t mem  [`QS_BANKS][`QS_DEPTH];
  w_t rd_q [`QS_BANKS];

  // Per bank single port after steering
  logic  we [`QS_BANKS];
  logic  re [`QS_BANKS];
  addr_t pa [`QS_BANKS];
  w_t    wd [`QS_BANKS];

  // Read back for the selected banks
  assign enq_status   = status_q[enq_bank_idx];
  assign sort_status  = status_q[sort_bank_idx];
  assign sort_n       = n_q[sort_bank_idx];
  assign sort_rd_data = rd_q[sort_bank_idx];
  assign deq_status   = status_q[deq_bank_idx];
  assign deq_n        = n_q[deq_bank_idx];
  assign deq_err      = err_q[deq_bank_idx];
  assign deq_rd_data  = rd_q[deq_bank_idx];

  // Record updates, only enqueue carries n and err
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int b = 0; b < `QS_BANKS; b++) begin
        status_q[b] <= BANK_IDLE;
        n_q[b]      <= '0;
        err_q[b]    <= 1'b0;
      end
    end else begin
      for (int b = 0; b < `QS_BANKS; b++) begin
        if (enq_upd_vld && enq_bank_idx == bank_id_t'(b)) begin
          status_q[b] <= enq_upd_status;
          n_q[b]      <= enq_upd_n;
          err_q[b]    <= enq_upd_err;
        end else if (sort_upd_vld && sort_bank_idx == bank_id_t'(b)) begin
          status_q[b] <= sort_upd_status;
        end else if (deq_upd_vld && deq_bank_idx == bank_id_t'(b)) begin
          status_q[b] <= deq_upd_status;
        end
      end
    end
  end

  // Port steering by bank status
  always_comb begin
    for (int b = 0; b < `QS_BANKS; b++) begin
      we[b] = 1'b0;
      re[b] = 1'b0;
      pa[b] = '0;
      wd[b] = '0;
      case (status_q[b])
        BANK_LOADING: begin
          if (enq_bank_idx == bank_id_t'(b)) begin
            we[b] = enq_wr_en;
            pa[b] = enq_wr_addr;
            wd[b] = enq_wr_data;
          end
        end
        BANK_SORTING: begin
          // Sort never reads and writes in one cycle
          if (sort_bank_idx == bank_id_t'(b)) begin
            we[b] = sort_wr_en;
            re[b] = sort_rd_en;
            pa[b] = sort_wr_en ? sort_wr_addr : sort_rd_addr;
            wd[b] = sort_wr_data;
          end
        end
        BANK_UNLOADING: begin
          if (deq_bank_idx == bank_id_t'(b)) begin
            re[b] = deq_rd_en;
            pa[b] = deq_rd_addr;
          end
        end
        default: ;
      endcase
    end
  end

  // Memories, one cycle read latency
  always_ff @(posedge clk) begin
    for (int b = 0; b < `QS_BANKS; b++) begin
      if (we[b]) begin
        mem[b][pa[b]] <= wd[b];
      end
      if (re[b]) begin
        rd_q[b] <= mem[b][pa[b]];
      end
    end
  end

  // Ownership keeps each bank record to a single updater
  a_one_updater: assert property (@(posedge clk) disable iff (!arst_n)
    !(enq_upd_vld && sort_upd_vld && enq_bank_idx == sort_bank_idx) &&
    !(enq_upd_vld && deq_upd_vld && enq_bank_idx == deq_bank_idx) &&
    !(sort_upd_vld && deq_upd_vld && sort_bank_idx == deq_bank_idx));

  // Writes land only in banks their client owns
  a_enq_owner: assert property (@(posedge clk) disable iff (!arst_n)
    enq_wr_en |-> status_q[enq_bank_idx] == BANK_LOADING);
  a_sort_owner: assert property (@(posedge clk) disable iff (!arst_n)
    sort_wr_en |-> status_q[sort_bank_idx] == BANK_SORTING);

endmodule

/* design/qs_enq.sv */
// Enqueue FSM, claims the next idle bank and loads one input packet into its memory
module qs_enq
  import qs_pkg::*;
(
  input  logic         clk,
  input  logic         arst_n,
  input  logic         in_vld,
  input  logic         in_sop,
  input  logic         in_eop,
  input  w_t           in_dat,
  output logic         in_rdy,
  input  bank_status_t bank_status,
  output bank_id_t     bank_idx,
  output logic         upd_vld,
  output bank_status_t upd_status,
  output addr_t        upd_n,
  output logic         upd_err,
  output logic         wr_en,
  output addr_t        wr_addr,
  output w_t           wr_data
);

  typedef enum logic {
    ST_IDLE,
    ST_LOAD
  } state_t;

  state_t state_q;
  addr_t  addr_q;
  logic   full_q;
  logic   ovf_q;
  logic   acc;

  // Word taken this cycle
  assign acc = in_vld & in_rdy;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q    <= ST_IDLE;
      in_rdy     <= 1'b0;
      bank_idx   <= '0;
      upd_vld    <= 1'b0;
      upd_status <= BANK_IDLE;
      wr_en      <= 1'b0;
      addr_q     <= '0;
      full_q     <= 1'b0;
      ovf_q      <= 1'b0;
    end else begin
      upd_vld <= 1'b0;
      // Words past the last slot are dropped
      wr_en   <= acc & ~full_q;
      // Move on only after READY has gone out for the old bank
      if (upd_vld && upd_status == BANK_READY) begin
        bank_idx <= bank_id_inc(bank_idx);
      end
      case (state_q)
        ST_IDLE: begin
          // Claim the selected bank once it drains
          if (bank_status == BANK_IDLE) begin
            upd_vld    <= 1'b1;
            upd_status <= BANK_LOADING;
            addr_q     <= '0;
            full_q     <= 1'b0;
            ovf_q      <= 1'b0;
            state_q    <= ST_LOAD;
          end
        end
        ST_LOAD: begin
          // Ready follows the state by one cycle, drops with eop
          in_rdy <= ~(acc & in_eop);
          if (acc) begin
            if (!full_q) begin
              addr_q <= addr_q + 1'b1;
              // Last slot written
              if (addr_q == '1) begin
                full_q <= 1'b1;
              end
            end else begin
              ovf_q <= 1'b1;
            end
            if (in_eop) begin
              upd_vld    <= 1'b1;
              upd_status <= BANK_READY;
              state_q    <= ST_IDLE;
            end
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Write port and record payload
  always_ff @(posedge clk) begin
    wr_addr <= addr_q;
    wr_data <= in_dat;
    if (state_q == ST_LOAD) begin
      // Index of last stored word, err if anything was dropped
      upd_n   <= full_q ? '1 : addr_q;
      upd_err <= ovf_q | full_q;
    end else begin
      upd_n   <= '0;
      upd_err <= 1'b0;
    end
  end

  // Memory writes only trail a word accepted during LOAD
  a_wr_in_load: assert property (@(posedge clk) disable iff (!arst_n)
    wr_en |-> $past(state_q) == ST_LOAD);

  // First accepted word of a load carries sop
  a_first_sop: assert property (@(posedge clk) disable iff (!arst_n)
    acc && addr_q == '0 && !full_q |-> in_sop);

endmodule

/* design/qs_pkg.sv */
// Shared types and bank index helper for the sort accelerator, imported by every RTL block
`include "qs_macros.svh"

package qs_pkg;

  // Bank index width, one bit minimum
  localparam int BANK_ID_W = (`QS_BANKS > 1) ? $clog2(`QS_BANKS) : 1;

  // Data word
  typedef logic [`QS_W-1:0] w_t;

  // Word index within one bank
  typedef logic [$clog2(`QS_DEPTH)-1:0] addr_t;

  // Bank selector
  typedef logic [BANK_ID_W-1:0] bank_id_t;

  // Bank life cycle, each pair of states owned by one client
  typedef enum logic [2:0] {
    BANK_IDLE,
    BANK_LOADING,
    BANK_READY,
    BANK_SORTING,
    BANK_SORTED,
    BANK_UNLOADING
  } bank_status_t;

  // Next bank in the fixed walk order, wraps after the last bank
  function automatic bank_id_t bank_id_inc(input bank_id_t idx);
    if (idx == bank_id_t'(`QS_BANKS - 1)) begin
      return '0;
    end
    return idx + 1'b1;
  endfunction

endpackage

/* design/qs_macros.svh */
// Size macros for the sort accelerator, included by the package and by any block that needs them
`ifndef QS_MACROS_SVH
`define QS_MACROS_SVH

// Data word width in bits
`define QS_W 32

// Number of banks in rotation
`define QS_BANKS 2

// Words per bank, power of two
`define QS_DEPTH 16

`endif
